//--- list.f
verilog/mem_pkg.sv
verilog/xfer_pkg.sv
verilog/addr_if.sv
verilog/addr_gen.sv
verilog/data_mem.sv
verilog/stream_out.sv
verilog/xfer_ctrl.sv
verilog/xfer_top.sv
tb/xfer_tb.sv

//--- tb/xfer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module xfer_tb;

   logic                     clk_i = 1'b0;
   logic                     rst_i;
   logic                     cfg_we_i;
   logic                     cfg_sel_i;
   logic [xfer_pkg::CFG_W-1:0] cfg_data_i;
   logic                     mem_we_i;
   mem_pkg::word_idx_t       mem_waddr_i;
   mem_pkg::word_t           mem_wdata_i;
   logic                     start_i;
   logic                     credit_i;
   wire                      busy_o;
   wire                      done_o;
   wire                      out_valid_o;
   wire  [mem_pkg::DATA_W-1:0] out_data_o;

   mem_pkg::word_t img [mem_pkg::MEM_DEPTH];  // copy of what the host loaded.
   mem_pkg::word_t got_q [$];                 // words seen on the output.
   int             seed = 32'h22812709;
   bit             credit_en = 1'b1;  // consumer returns credits when set.
   int             credit_gap = 0;    // idle cycles before each returned credit.
   int             owed = 0;          // words received but not yet credited.
   int             gap_cnt = 0;

   xfer_top u_dut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_sel_i   (cfg_sel_i),
      .cfg_data_i  (cfg_data_i),
      .mem_we_i    (mem_we_i),
      .mem_waddr_i (mem_waddr_i),
      .mem_wdata_i (mem_wdata_i),
      .start_i     (start_i),
      .credit_i    (credit_i),
      .busy_o      (busy_o),
      .done_o      (done_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o)
   );

   always #20 clk_i = ~clk_i;  // 40 ns period.

   always @(posedge clk_i) begin
      if (out_valid_o === 1'b1) begin
         got_q.push_back(out_data_o);
      end
   end

   // consumer side. each received word earns one credit back after the gap.
   always @(posedge clk_i) begin
      credit_i <= 1'b0;
      if (out_valid_o === 1'b1) begin
         owed = owed + 1;
      end
      if (credit_en && owed > 0) begin
         if (gap_cnt >= credit_gap) begin
            credit_i <= 1'b1;
            owed = owed - 1;
            gap_cnt = 0;
         end else begin
            gap_cnt = gap_cnt + 1;
         end
      end else begin
         gap_cnt = 0;
      end
   end

   task automatic abort_run(input string what);
      $display("error at %0t ns: %s", $time, what);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input mem_pkg::word_t got,
                             input mem_pkg::word_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
         abort_run("output word differs from the memory image");
      end
   endtask

   task automatic check_count(input string name, input logic [xfer_pkg::PERIOD_W-1:0] got,
                              input logic [xfer_pkg::PERIOD_W-1:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
         abort_run("wrong number of words");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
         abort_run("control output has the wrong level");
      end
   endtask

   task automatic load_memory();
      for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
         img[i] = $random(seed);
      end
      for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
         @(posedge clk_i);
         mem_we_i    <= 1'b1;
         mem_waddr_i <= mem_pkg::word_idx_t'(i);
         mem_wdata_i <= img[i];
      end
      @(posedge clk_i);
      mem_we_i <= 1'b0;
   endtask

   task automatic write_cfg(input logic sel, input xfer_pkg::cfg_word_u data);
      @(posedge clk_i);
      cfg_we_i   <= 1'b1;
      cfg_sel_i  <= sel;
      cfg_data_i <= data;
      @(posedge clk_i);
      cfg_we_i <= 1'b0;
   endtask

   task automatic set_config(input int start, input int incr, input int period, input int delay);
      xfer_pkg::cfg_word_u cw;
      cw = '0;
      cw.addr.start = start[mem_pkg::ADDR_W-1:0];
      cw.addr.incr  = incr[xfer_pkg::PERIOD_W-1:0];
      write_cfg(1'b0, cw);  // address view.
      cw = '0;
      cw.timing.period = period[xfer_pkg::PERIOD_W-1:0];
      cw.timing.delay  = delay[xfer_pkg::DELAY_W-1:0];
      write_cfg(1'b1, cw);
   endtask

   task automatic pulse_start();
      @(posedge clk_i);
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
   endtask

   task automatic wait_words(input int n, input int limit);
      int cycles;
      cycles = 0;
      while (got_q.size() < n) begin
         if (cycles >= limit) begin
            abort_run($sformatf("timeout waiting for %0d output words", n));
         end
         @(posedge clk_i);
         cycles++;
      end
   endtask

   // done_o is a one-cycle pulse and busy_o must fall with it.
   task automatic wait_done(input int limit);
      int   cycles;
      bit   seen;
      logic busy_prev;
      cycles = 0;
      seen = 1'b0;
      busy_prev = busy_o;
      while (!seen) begin
         if (cycles >= limit) begin
            abort_run("timeout waiting for done_o");
         end
         @(posedge clk_i);
         cycles++;
         if (done_o === 1'b1) begin
            seen = 1'b1;
            check_flag("busy_o before done_o", busy_prev, 1'b1);
            check_flag("busy_o at done_o", busy_o, 1'b0);
         end
         busy_prev = busy_o;
      end
   endtask

   task automatic wait_credits_back(input int limit);
      int cycles;
      cycles = 0;
      while (owed != 0) begin
         if (cycles >= limit) begin
            abort_run("timeout waiting for the consumer to return all credits");
         end
         @(posedge clk_i);
         cycles++;
      end
      repeat (2) @(posedge clk_i);  // last credit pulse reaches the counter.
   endtask

   // expected words follow the strided byte address rule, modulo 1 KiB.
   task automatic check_stream(input int start, input int incr, input int period);
      int n;
      int addr;
      n = (period < 2) ? 1 : period;
      check_count("word count", got_q.size(), n);
      for (int k = 0; k < n; k++) begin
         addr = (start + k * incr * 4) % 1024;
         if (addr < 0) begin
            addr = addr + 1024;
         end
         check_word($sformatf("out_data_o[%0d]", k), got_q[k], img[addr / 4]);
      end
   endtask

   task automatic do_transfer(input int start, input int incr, input int period,
                              input int delay, input int gap);
      check_flag("busy_o before start", busy_o, 1'b0);
      set_config(start, incr, period, delay);
      credit_gap = gap;
      got_q.delete();
      pulse_start();
      wait_done(2000);
      wait_credits_back(200);
      check_stream(start, incr, period);
   endtask

   task automatic test_forward();
      do_transfer(0, 1, 8, 0, 0);
   endtask

   task automatic test_negative_stride();
      do_transfer(8, -3, 6, 0, 1);  // runs below zero and wraps to the top.
   endtask

   task automatic test_delay();
      set_config(200, 2, 5, 20);
      credit_gap = 0;
      got_q.delete();
      pulse_start();
      repeat (20) begin
         @(posedge clk_i);
         check_flag("out_valid_o during delay", out_valid_o, 1'b0);
      end
      wait_done(2000);
      wait_credits_back(200);
      check_stream(200, 2, 5);
      do_transfer(100, 5, 0, 2, 0);
      do_transfer(1020, -1, 1, 0, 0);
   endtask

   task automatic test_backpressure();
      set_config(64, 1, 10, 0);
      credit_en = 1'b0;
      got_q.delete();
      pulse_start();
      wait_words(xfer_pkg::CREDIT_INIT, 200);
      repeat (50) begin
         @(posedge clk_i);
         if (got_q.size() != xfer_pkg::CREDIT_INIT) begin
            abort_run("a word arrived while the consumer held back all credits");
         end
      end
      check_flag("busy_o while stalled", busy_o, 1'b1);
      credit_en = 1'b1;
      wait_done(2000);
      wait_credits_back(200);
      check_stream(64, 1, 10);
   endtask

   task automatic test_random();
      int start;
      int incr;
      int period;
      int delay;
      int gap;
      for (int t = 0; t < 8; t++) begin
         start  = $random(seed) & 32'h3ff;
         incr   = $random(seed) % 512;
         period = $random(seed) & 32'hf;
         delay  = $random(seed) & 32'h7;
         gap    = $random(seed) & 32'h3;
         do_transfer(start, incr, period, delay, gap);
      end
   endtask

   task automatic test_start_busy();
      set_config(40, 2, 10, 0);
      credit_gap = 2;
      got_q.delete();
      pulse_start();
      repeat (3) @(posedge clk_i);
      check_flag("busy_o before second start", busy_o, 1'b1);
      pulse_start();  // must be ignored.
      wait_done(2000);
      repeat (20) @(posedge clk_i);
      check_flag("busy_o after transfer", busy_o, 1'b0);
      wait_credits_back(200);
      check_stream(40, 2, 10);
   endtask

   initial begin
      rst_i       <= 1'b1;
      cfg_we_i    <= 1'b0;
      cfg_sel_i   <= 1'b0;
      cfg_data_i  <= '0;
      mem_we_i    <= 1'b0;
      mem_waddr_i <= '0;
      mem_wdata_i <= '0;
      start_i     <= 1'b0;
      credit_i    <= 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      load_memory();
      test_forward();
      test_negative_stride();
      test_delay();
      test_backpressure();
      test_random();
      test_start_busy();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module addr_gen (
   input  wire                                 clk_i,
   input  wire                                 rst_i,
   input  wire                                 run_i,
   input  wire  [xfer_pkg::PERIOD_W-1:0]       period_i,
   input  wire  [xfer_pkg::DELAY_W-1:0]        delay_i,
   input  wire  mem_pkg::byte_addr_t           start_i,
   input  wire  signed [xfer_pkg::PERIOD_W-1:0] incr_i,
   addr_if.generator                           a
);

   logic [xfer_pkg::DELAY_W-1:0]  delay_cnt;  // cycles left before the first address.
   logic [xfer_pkg::PERIOD_W-1:0] word_cnt;   // addresses accepted so far, less one.
   logic                          last_word;
   mem_pkg::byte_addr_t           step;

   // a period of 0 or 1 still ends after the first word.
   assign last_word = ({1'b0, word_cnt} + 1'b1) >= {1'b0, period_i};

   // the word step in bytes, wrapping in the 1 KiB space.
   assign step = mem_pkg::byte_addr_t'(incr_i <<< mem_pkg::OFFSET_W);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_cnt <= '0;
         word_cnt  <= '0;
         a.addr    <= '0;
         a.valid   <= 1'b0;
         a.done    <= 1'b0;
      end else if (run_i) begin
         delay_cnt <= delay_i;
         word_cnt  <= '0;
         a.addr    <= start_i;
         a.valid   <= (delay_i == '0);  // no delay, offer at once.
         a.done    <= 1'b0;
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
         a.valid   <= (delay_cnt == xfer_pkg::DELAY_W'(1));  // the delay runs out here.
      end else if (a.valid && a.ready) begin
         if (last_word) begin
            a.valid <= 1'b0;
            a.done  <= 1'b1;  // held until the next run.
         end else begin
            a.addr   <= a.addr + step;
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/addr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface addr_if;

   logic                valid;  // an address is offered.
   logic                ready;  // the streamer holds at least one credit.
   mem_pkg::byte_addr_t addr;
   logic                done;   // all addresses of the transfer are accepted.

   modport generator (output valid, output addr, output done, input ready);

   modport consumer (input valid, output ready);

   // the memory reads on every accepted address.
   modport observer (input valid, input ready, input addr);

   modport controller (input valid, input ready, input done);

endinterface

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem (
   input  wire                clk_i,
   input  wire                we_i,
   input  wire  mem_pkg::word_idx_t waddr_i,
   input  wire  mem_pkg::word_t     wdata_i,
   addr_if.observer           a,
   output mem_pkg::word_t     rdata_o
);

   mem_pkg::word_t     mem [mem_pkg::MEM_DEPTH];
   mem_pkg::word_idx_t ridx;

   // drop the byte offset to get the word index.
   assign ridx = a.addr[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;  // host load.
      end
   end

   always_ff @(posedge clk_i) begin
      if (a.valid && a.ready) begin
         rdata_o <= mem[ridx];  // valid the cycle after acceptance.
      end
   end

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

   // byte address space of the engine, 1 KiB.
   localparam int ADDR_W = 10;

   // one memory word.
   localparam int DATA_W = 32;

   localparam int OFFSET_W = $clog2(DATA_W / 8);  // address bits below a word.

   localparam int MEM_DEPTH = 256;  // words held by the memory.

   localparam int WORD_IDX_W = ADDR_W - OFFSET_W;  // index bits of a word.

   typedef logic [ADDR_W-1:0] byte_addr_t;  // byte address as issued by the generator.

   typedef logic [DATA_W-1:0] word_t;

   typedef logic [WORD_IDX_W-1:0] word_idx_t;  // memory word index, byte address over four.

endpackage

`default_nettype wire

//--- verilog/stream_out.sv
`timescale 1ns/100ps
`default_nettype none

module stream_out (
   input  wire             clk_i,
   input  wire             rst_i,
   addr_if.consumer        a,
   input  wire  mem_pkg::word_t rdata_i,
   input  wire             credit_i,
   output logic            out_valid_o,
   output mem_pkg::word_t  out_data_o
);

   localparam logic [xfer_pkg::CREDIT_W-1:0] CREDIT_FULL =
      xfer_pkg::CREDIT_W'(xfer_pkg::CREDIT_INIT);

   logic [xfer_pkg::CREDIT_W-1:0] credits;
   logic                          accept;

   assign a.ready = (credits != '0);  // only accept while a credit is left.
   assign accept  = a.valid && a.ready;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         credits <= CREDIT_FULL;
      end else begin
         case ({accept, credit_i})
            2'b10: begin
               credits <= credits - 1'b1;  // one word sent.
            end
            2'b01: begin
               if (credits != CREDIT_FULL) begin
                  credits <= credits + 1'b1;  // returned by the consumer.
               end
            end
            default: begin
               credits <= credits;  // spend and return cancel.
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= accept;  // lines up with the memory read.
      end
   end

   // the memory read register is the output stage and holds until the next acceptance.
   assign out_data_o = rdata_i;

endmodule

`default_nettype wire

//--- verilog/xfer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module xfer_ctrl (
   input  wire                             clk_i,
   input  wire                             rst_i,
   input  wire                             cfg_we_i,
   input  wire                             cfg_sel_i,
   input  wire  xfer_pkg::cfg_word_u       cfg_data_i,
   input  wire                             start_i,
   addr_if.controller                      a,
   input  wire                             out_valid_i,
   output logic                            run_o,
   output logic [xfer_pkg::PERIOD_W-1:0]   period_o,
   output logic [xfer_pkg::DELAY_W-1:0]    delay_o,
   output mem_pkg::byte_addr_t             start_addr_o,
   output logic signed [xfer_pkg::PERIOD_W-1:0] incr_o,
   output logic                            busy_o,
   output logic                            done_o
);

   xfer_pkg::addr_cfg_t   addr_cfg;
   xfer_pkg::timing_cfg_t timing_cfg;
   logic                  in_flight;  // a word accepted but not yet on the output.
   logic                  accept;
   logic                  finish;

   assign accept = a.valid && a.ready;

   // done from the previous transfer is stale while run is still high.
   assign finish = busy_o && !run_o && a.done && (!in_flight || out_valid_i);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         addr_cfg   <= '0;
         timing_cfg <= '0;
      end else if (cfg_we_i) begin
         if (cfg_sel_i) begin
            timing_cfg <= cfg_data_i.timing;
         end else begin
            addr_cfg <= cfg_data_i.addr;
         end
      end
   end

   assign period_o     = timing_cfg.period;
   assign delay_o      = timing_cfg.delay;
   assign start_addr_o = addr_cfg.start;
   assign incr_o       = addr_cfg.incr;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_o <= 1'b0;
         run_o  <= 1'b0;
         done_o <= 1'b0;
      end else begin
         run_o  <= 1'b0;
         done_o <= finish;  // one cycle pulse.
         if (!busy_o && start_i) begin
            busy_o <= 1'b1;
            run_o  <= 1'b1;
         end else if (finish) begin
            busy_o <= 1'b0;
         end
      end
   end

   // Back-to-back acceptances keep one word in flight, so accept wins.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         in_flight <= 1'b0;
      end else if (accept) begin
         in_flight <= 1'b1;
      end else if (out_valid_i) begin
         in_flight <= 1'b0;  // the word has left.
      end
   end

endmodule

`default_nettype wire

//--- verilog/xfer_pkg.sv
`default_nettype none

package xfer_pkg;

   localparam int CFG_W = 32;  // width of one configuration word.

   localparam int PERIOD_W = 10;  // word count, also the width of the signed increment.

   localparam int DELAY_W = 8;

   localparam int ADDR_RSVD_W = CFG_W - mem_pkg::ADDR_W - PERIOD_W;
   localparam int TIMING_RSVD_W = CFG_W - PERIOD_W - DELAY_W;

   localparam int CREDIT_INIT = 4;  // credits held after reset.
   localparam int CREDIT_W = 3;  // wide enough to hold CREDIT_INIT.

   // address view, written with select 0.
   typedef struct packed {
      logic [ADDR_RSVD_W-1:0]     rsvd;
      logic signed [PERIOD_W-1:0] incr;   // signed step in words.
      mem_pkg::byte_addr_t        start;  // first byte address.
   } addr_cfg_t;

   // timing view, written with select 1.
   typedef struct packed {
      logic [TIMING_RSVD_W-1:0] rsvd;
      logic [DELAY_W-1:0]       delay;   // idle cycles after run.
      logic [PERIOD_W-1:0]      period;  // words per transfer, 0 and 1 give one.
   } timing_cfg_t;

   typedef union packed {
      addr_cfg_t   addr;
      timing_cfg_t timing;
   } cfg_word_u;

endpackage

`default_nettype wire

//--- verilog/xfer_top.sv
`timescale 1ns/100ps
`default_nettype none

module xfer_top (
   input  wire                              clk_i,
   input  wire                              rst_i,
   input  wire                              cfg_we_i,
   input  wire                              cfg_sel_i,
   input  wire  [xfer_pkg::CFG_W-1:0]       cfg_data_i,
   input  wire                              mem_we_i,
   input  wire  [mem_pkg::WORD_IDX_W-1:0]   mem_waddr_i,
   input  wire  [mem_pkg::DATA_W-1:0]       mem_wdata_i,
   input  wire                              start_i,
   input  wire                              credit_i,
   output wire                              busy_o,
   output wire                              done_o,
   output wire                              out_valid_o,
   output wire  [mem_pkg::DATA_W-1:0]       out_data_o
);

   wire                                 run;
   wire [xfer_pkg::PERIOD_W-1:0]        period;
   wire [xfer_pkg::DELAY_W-1:0]         delay;
   wire mem_pkg::byte_addr_t            start_addr;
   wire signed [xfer_pkg::PERIOD_W-1:0] incr;
   wire mem_pkg::word_t                 rdata;

   addr_if u_addr_if ();

   xfer_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_sel_i    (cfg_sel_i),
      .cfg_data_i   (cfg_data_i),
      .start_i      (start_i),
      .a            (u_addr_if.controller),
      .out_valid_i  (out_valid_o),
      .run_o        (run),
      .period_o     (period),
      .delay_o      (delay),
      .start_addr_o (start_addr),
      .incr_o       (incr),
      .busy_o       (busy_o),
      .done_o       (done_o)
   );

   addr_gen u_addr_gen (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .run_i    (run),
      .period_i (period),
      .delay_i  (delay),
      .start_i  (start_addr),
      .incr_i   (incr),
      .a        (u_addr_if.generator)
   );

   data_mem u_mem (
      .clk_i   (clk_i),
      .we_i    (mem_we_i),
      .waddr_i (mem_waddr_i),
      .wdata_i (mem_wdata_i),
      .a       (u_addr_if.observer),
      .rdata_o (rdata)
   );

   stream_out u_stream (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .a           (u_addr_if.consumer),
      .rdata_i     (rdata),
      .credit_i    (credit_i),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o)
   );

endmodule

`default_nettype wire
